//--- src/sw_settings.svh
`ifndef SW_SETTINGS_SVH
`define SW_SETTINGS_SVH

// bases per sequence, also the number of cells
`define SW_LEN          16

// signed score width
`define SW_SCORE_W      10

// affine scoring
`define SW_MATCH        1
`define SW_MISMATCH     (-4)
`define SW_GAP_OPEN     (-6)
`define SW_GAP_EXTEND   (-1)

`endif

//--- src/sw_pkg.sv
`default_nettype none

`include "sw_settings.svh"

package sw_pkg;

    typedef logic [1:0] sw_base_t;
    typedef logic signed [`SW_SCORE_W-1:0] sw_score_t;
    typedef logic [$clog2(`SW_LEN)-1:0] sw_idx_t;

    // base 0 sits at the msb end
    typedef sw_base_t [0:`SW_LEN-1] sw_seq_t;

    typedef struct packed {
        sw_seq_t ref_seq;
        sw_seq_t read_seq;
    } sw_job_t;

    typedef struct packed {
        sw_score_t align;
        sw_score_t ins;
        sw_score_t del;
    } sw_cell_t;

    typedef struct packed {
        sw_score_t score;
        sw_idx_t   col;
    } sw_row_best_t;

    typedef struct packed {
        sw_score_t score;
        sw_idx_t   row;
        sw_idx_t   col;
    } sw_result_t;

endpackage

`default_nettype wire

//--- src/sw_cell.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_cell
    import sw_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_ref_valid,
    input  sw_base_t i_ref_base,
    input  sw_base_t i_read_base,
    input  sw_cell_t i_diag,
    input  sw_cell_t i_top,
    output logic     o_ref_valid,
    output sw_base_t o_ref_base,
    output sw_cell_t o_cell
);

    localparam sw_score_t MATCH    = sw_score_t'(`SW_MATCH);
    localparam sw_score_t MISMATCH = sw_score_t'(`SW_MISMATCH);
    localparam sw_score_t GAP_OPEN = sw_score_t'(`SW_GAP_OPEN);
    localparam sw_score_t GAP_EXT  = sw_score_t'(`SW_GAP_EXTEND);
    localparam sw_score_t ZERO     = '0;

    sw_cell_t  left;
    sw_cell_t  cell_next;
    sw_score_t subst;

    function automatic sw_score_t max2(sw_score_t a, sw_score_t b);
        return (a > b) ? a : b;
    endfunction

    // left neighbour is only real while the previous column came in last cycle,
    // so the first column of a run sees the zero boundary
    assign left  = o_ref_valid ? o_cell : '0;
    assign subst = (i_ref_base == i_read_base) ? MATCH : MISMATCH;

    always_comb begin
        // gap in the reference, from the row above
        cell_next.ins = max2(max2(i_top.align + GAP_OPEN, i_top.ins + GAP_EXT), ZERO);
        // gap in the read, from the column to the left
        cell_next.del = max2(max2(left.align + GAP_OPEN, left.del + GAP_EXT), ZERO);
        cell_next.align = max2(max2(i_diag.align + subst, cell_next.ins),
                               max2(cell_next.del, ZERO));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_ref_valid <= 1'b0;
            o_ref_base  <= '0;
            o_cell      <= '0;
        end else begin
            o_ref_valid <= i_ref_valid;
            o_ref_base  <= i_ref_base;
            // scores hold between bases
            if (i_ref_valid) begin
                o_cell <= cell_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sw_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_array
    import sw_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_clear,
    input  logic         i_load,
    input  logic         i_feed,
    input  logic         i_calc,
    input  sw_job_t      i_job,
    input  sw_idx_t      i_sel_row,
    output sw_row_best_t o_row_best
);

    localparam int CNT_W = $clog2(2 * `SW_LEN);
    localparam int IDX_W = $bits(sw_idx_t);

    sw_seq_t            read_q;
    sw_seq_t            ref_shift;
    logic [CNT_W-1:0]   calc_cnt;

    logic               ref_valid [`SW_LEN];
    sw_base_t           ref_base  [`SW_LEN];
    sw_cell_t           cell_out  [`SW_LEN];
    sw_row_best_t       row_best  [`SW_LEN];

    always_ff @(posedge clk) begin
        if (i_load) begin
            read_q    <= i_job.read_seq;
            ref_shift <= i_job.ref_seq;
        end else if (i_feed) begin
            ref_shift <= ref_shift << $bits(sw_base_t);
        end
    end

    // cycles since calc began, for the column of each fresh cell output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            calc_cnt <= '0;
        end else if (i_load) begin
            calc_cnt <= '0;
        end else if (i_calc) begin
            calc_cnt <= calc_cnt + 1'b1;
        end
    end

    for (genvar i = 0; i < `SW_LEN; i++) begin : g_cell
        logic             in_valid;
        sw_base_t         in_base;
        sw_cell_t         top_in;
        sw_cell_t         diag_in;
        sw_row_best_t     best_q;
        logic [CNT_W-1:0] col_w;

        if (i == 0) begin : g_head
            assign in_valid = i_feed;
            assign in_base  = ref_shift[0];
            assign top_in   = '0;
            assign diag_in  = '0;
        end else begin : g_body
            sw_cell_t diag_q;

            // top of last cycle, zero before the row above has a column
            always_ff @(posedge clk) begin
                diag_q <= ref_valid[i-1] ? cell_out[i-1] : '0;
            end

            assign in_valid = ref_valid[i-1];
            assign in_base  = ref_base[i-1];
            assign top_in   = cell_out[i-1];
            assign diag_in  = diag_q;
        end

        sw_cell u_cell (
            .clk         (clk),
            .rst         (rst),
            .i_ref_valid (in_valid),
            .i_ref_base  (in_base),
            .i_read_base (read_q[i]),
            .i_diag      (diag_in),
            .i_top       (top_in),
            .o_ref_valid (ref_valid[i]),
            .o_ref_base  (ref_base[i]),
            .o_cell      (cell_out[i])
        );

        assign col_w = calc_cnt - CNT_W'(i + 1);

        // first column of the strictly largest H in this row
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                best_q <= '0;
            end else if (i_clear) begin
                best_q <= '0;
            end else if (ref_valid[i] && (cell_out[i].align > best_q.score)) begin
                best_q.score <= cell_out[i].align;
                best_q.col   <= col_w[IDX_W-1:0];
            end
        end

        assign row_best[i] = best_q;
    end

    assign o_row_best = row_best[i_sel_row];

endmodule

`default_nettype wire

//--- src/sw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_ctrl
    import sw_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    i_valid,
    input  logic    i_ready,
    output logic    o_ready,
    output logic    o_valid,
    output logic    o_clear,
    output logic    o_load,
    output logic    o_feed,
    output logic    o_calc,
    output logic    o_select,
    output sw_idx_t o_row
);

    localparam int CNT_W = $clog2(2 * `SW_LEN);
    localparam logic [CNT_W-1:0] CALC_LAST = CNT_W'(2 * `SW_LEN - 1);
    localparam logic [CNT_W-1:0] SEL_LAST  = CNT_W'(`SW_LEN - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_SELECT,
        S_DONE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_valid) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_CALC;
                    cnt   <= '0;
                end
                S_CALC: begin
                    cnt <= (cnt == CALC_LAST) ? '0 : cnt + 1'b1;
                    if (cnt == CALC_LAST) begin
                        state <= S_SELECT;
                    end
                end
                S_SELECT: begin
                    cnt <= (cnt == SEL_LAST) ? '0 : cnt + 1'b1;
                    if (cnt == SEL_LAST) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (o_valid && i_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // result settles during the first done cycle, valid follows one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= (state == S_DONE) && !(o_valid && i_ready);
        end
    end

    assign o_ready  = (state == S_IDLE);
    assign o_clear  = (state == S_IDLE);
    assign o_load   = o_ready && i_valid;
    assign o_calc   = (state == S_CALC);
    // reference bases go in during the first half of calc
    assign o_feed   = o_calc && !cnt[CNT_W-1];
    assign o_select = (state == S_SELECT);
    assign o_row    = cnt[$bits(sw_idx_t)-1:0];

endmodule

`default_nettype wire

//--- src/sw_best_select.sv
`timescale 1ns/1ps
`default_nettype none

module sw_best_select
    import sw_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_clear,
    input  logic         i_select,
    input  sw_idx_t      i_row,
    input  sw_row_best_t i_row_best,
    output sw_result_t   o_result
);

    sw_result_t best_q;

    // rows come in ascending order, so strict compare keeps the lowest row on ties
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_q <= '0;
        end else if (i_clear) begin
            best_q <= '0;
        end else if (i_select && (i_row_best.score > best_q.score)) begin
            best_q.score <= i_row_best.score;
            best_q.row   <= i_row;
            best_q.col   <= i_row_best.col;
        end
    end

    assign o_result = best_q;

endmodule

`default_nettype wire

//--- src/sw_core.sv
`timescale 1ns/1ps
`default_nettype none

module sw_core
    import sw_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_valid,
    output logic       o_ready,
    input  sw_job_t    i_job,
    output logic       o_valid,
    input  logic       i_ready,
    output sw_result_t o_result
);

    logic         clear;
    logic         load;
    logic         feed;
    logic         calc;
    logic         sel;
    sw_idx_t      row;
    sw_row_best_t row_best;

    sw_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_ready  (i_ready),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_clear  (clear),
        .o_load   (load),
        .o_feed   (feed),
        .o_calc   (calc),
        .o_select (sel),
        .o_row    (row)
    );

    sw_array u_array (
        .clk        (clk),
        .rst        (rst),
        .i_clear    (clear),
        .i_load     (load),
        .i_feed     (feed),
        .i_calc     (calc),
        .i_job      (i_job),
        .i_sel_row  (row),
        .o_row_best (row_best)
    );

    sw_best_select u_select (
        .clk        (clk),
        .rst        (rst),
        .i_clear    (clear),
        .i_select   (sel),
        .i_row      (row),
        .i_row_best (row_best),
        .o_result   (o_result)
    );

endmodule

`default_nettype wire

//--- testbench/sw_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_core_properties
    import sw_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       i_valid,
    input wire logic       o_ready,
    input wire logic       o_valid,
    input wire logic       i_ready,
    input wire sw_result_t o_result
);

    // accept edge to first sampled high o_valid
    localparam int LAT = 3 * `SW_LEN + 3;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(o_valid && o_ready))
        else $error("o_valid and o_ready high together");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_result)))
        else $error("result changed during back-pressure");

    a_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(o_valid) |-> $past(i_valid && o_ready, LAT))
        else $error("o_valid rose at the wrong cycle");

endmodule

bind sw_core sw_core_properties u_props (.*);

`default_nettype wire

//--- testbench/tb_sw_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module tb_sw_core
    import sw_pkg::*;
();

    localparam int NUM_JOBS = 7;
    localparam int WORDS    = 5;
    localparam int TIMEOUT  = NUM_JOBS * (3 * `SW_LEN + 2 + 8) + 100;

    logic       clk;
    logic       rst;
    logic       i_valid;
    logic       o_ready;
    sw_job_t    i_job;
    logic       o_valid;
    logic       i_ready;
    sw_result_t o_result;

    logic [31:0] pat [NUM_JOBS * WORDS];
    int          errors;
    int          checks;
    int          cycles;

    sw_core dut (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .i_job    (i_job),
        .o_valid  (o_valid),
        .i_ready  (i_ready),
        .o_result (o_result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the DUT gave no result within %0d cycles", TIMEOUT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic expect_result(input int base);
        check("o_result.score", 32'(o_result.score), pat[base + 2]);
        check("o_result.row", 32'(o_result.row), pat[base + 3]);
        check("o_result.col", 32'(o_result.col), pat[base + 4]);
    endtask

    task automatic run_job(input int job);
        int         base;
        int         stall;
        sw_result_t held;
        base = job * WORDS;
        i_valid = 1'b1;
        i_job.ref_seq  = pat[base];
        i_job.read_seq = pat[base + 1];
        while (!o_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_job   = '0;
        while (!o_valid) begin
            @(negedge clk);
        end
        expect_result(base);
        held  = o_result;
        stall = $urandom % 8;
        // back-pressure, result must hold
        repeat (stall) begin
            @(negedge clk);
            check("o_valid", 32'(o_valid), 32'd1);
            check("o_ready", 32'(o_ready), 32'd0);
            check("o_result", 32'(o_result), 32'(held));
        end
        i_ready = 1'b1;
        @(negedge clk);
        i_ready = 1'b0;
        check("o_valid", 32'(o_valid), 32'd0);
        check("o_ready", 32'(o_ready), 32'd1);
    endtask

    initial begin
        void'($urandom(41975));
        clk     = 1'b0;
        rst     = 1'b1;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_job   = '0;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        $readmemh("testbench/sw_patterns.mem", pat);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check("o_ready", 32'(o_ready), 32'd1);
        check("o_valid", 32'(o_valid), 32'd0);
        check("o_result", 32'(o_result), 32'd0);

        // jobs run back to back
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/sw_pkg.sv
src/sw_cell.sv
src/sw_array.sv
src/sw_ctrl.sv
src/sw_best_select.sv
src/sw_core.sv
testbench/sw_core_properties.sv
testbench/tb_sw_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       := tb_sw_core
RTL_TOP   := sw_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "=== FAIL ===" $(LOG)
	@grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/sw_patterns.mem
// one job per line: ref_seq read_seq score row col
// sequences hold base 0 in the top two bits (A=0 C=1 G=2 T=3)
1B1B1B1B 1B1B1B1B 00000010 0000000F 0000000F
00000000 FFFFFFFF 00000000 00000000 00000000
54554555 00000000 00000001 00000000 00000003
5D555455 A8AAEAAA 00000001 00000003 0000000B
00000000 00004000 0000000B 0000000F 0000000F
1113BBB9 1112EEEE 00000009 0000000F 0000000E
00000000 00000000 00000010 0000000F 0000000F
